//--- src/switch_pkg.sv
//////////////////////////////////////////////////
// Switch core shared definitions
// Port count, beat and MAC widths, common types
//////////////////////////////////////////////////
package switch_pkg;

	// Number of switch ports, types below are sized by it
	localparam int NPORT = 4;

	localparam int MAC_W = 48;
	localparam int BEAT_W = 96;
	localparam int PORT_ID_W = 2;

	typedef logic [MAC_W-1:0] mac_t;
	typedef logic [BEAT_W-1:0] beat_t;

	// One bit per port
	typedef logic [NPORT-1:0] port_mask_t;
	typedef logic [PORT_ID_W-1:0] port_id_t;

	//////////////////////////////////////////////////
	// Ingress packet FSM
	//////////////////////////////////////////////////
	typedef enum logic [1:0] {
		ING_IDLE,
		ING_LOOKUP,
		ING_FORWARD,
		ING_DROP
	} ingress_state_t;

endpackage

//--- src/rr_arbiter.sv
//////////////////////////////////////////////////
// Round-robin arbiter with grant hold
// Owner keeps the grant while it requests
//////////////////////////////////////////////////
`timescale 1ns/1ps

module rr_arbiter (
	input logic i_clk,
	input logic i_reset,
	input switch_pkg::port_mask_t i_req,
	output switch_pkg::port_mask_t o_grant
);

	switch_pkg::port_mask_t r_owner;
	switch_pkg::port_id_t r_last;
	switch_pkg::port_id_t cand;
	switch_pkg::port_id_t grant_id;
	logic found;

	// Current owner first, otherwise search from the port after the last one
	always_comb
	begin
		o_grant = '0;
		grant_id = r_last;
		found = 1'b0;
		cand = '0;
		if (|(r_owner & i_req))
		begin
			o_grant = r_owner;
			found = 1'b1;
		end
		for (int k = 1; k <= switch_pkg::NPORT; k++)
		begin
			cand = switch_pkg::port_id_t'(r_last + k);
			if (!found && i_req[cand])
			begin
				o_grant = switch_pkg::port_mask_t'(1) << cand;
				grant_id = cand;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_owner <= '0;
			r_last <= switch_pkg::port_id_t'(switch_pkg::NPORT - 1);
		end
		else
		begin
			r_owner <= o_grant;
			// Pointer settles on the new owner when it is first granted
			if (|o_grant && !(|(r_owner & i_req)))
				r_last <= grant_id;
		end
	end

endmodule

//--- src/route_table.sv
//////////////////////////////////////////////////
// MAC routing table
// Learns source MACs, looks up destinations,
// one requester at a time through an arbiter
//////////////////////////////////////////////////
`timescale 1ns/1ps

module route_table #(
	parameter int TBL_DEPTH = 4
) (
	input logic i_clk,
	input logic i_reset,
	input switch_pkg::port_mask_t i_lkup_req,
	input switch_pkg::mac_t [switch_pkg::NPORT-1:0] i_lkup_src,
	input switch_pkg::mac_t [switch_pkg::NPORT-1:0] i_lkup_dst,
	output switch_pkg::port_mask_t o_lkup_ack,
	output switch_pkg::port_mask_t o_lkup_mask
);

	localparam int IDX_W = (TBL_DEPTH > 1) ? $clog2(TBL_DEPTH) : 1;

	logic [TBL_DEPTH-1:0] r_valid;
	switch_pkg::mac_t r_mac [TBL_DEPTH];
	switch_pkg::port_id_t r_port [TBL_DEPTH];
	logic [IDX_W-1:0] r_repl;

	switch_pkg::port_mask_t grant;
	switch_pkg::port_id_t sel;
	switch_pkg::mac_t src_mac;
	switch_pkg::mac_t dst_mac;
	switch_pkg::port_mask_t mask;
	logic start;
	logic dst_hit, src_hit, free_found;
	logic [IDX_W-1:0] dst_idx, src_idx, free_idx, wr_idx;

	rr_arbiter u_arb (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_req(i_lkup_req),
		.o_grant(grant)
	);

	// No new lookup while the previous one is being acked
	assign start = (|grant) && !(|o_lkup_ack);

	always_comb
	begin
		sel = '0;
		for (int p = 0; p < switch_pkg::NPORT; p++)
			if (grant[p])
				sel = switch_pkg::port_id_t'(p);
		src_mac = i_lkup_src[sel];
		dst_mac = i_lkup_dst[sel];

		dst_hit = 1'b0;
		src_hit = 1'b0;
		free_found = 1'b0;
		dst_idx = '0;
		src_idx = '0;
		free_idx = '0;
		// Descending so the lowest free entry wins
		for (int e = TBL_DEPTH - 1; e >= 0; e--)
		begin
			if (r_valid[e] && r_mac[e] == dst_mac)
			begin
				dst_hit = 1'b1;
				dst_idx = IDX_W'(e);
			end
			if (r_valid[e] && r_mac[e] == src_mac)
			begin
				src_hit = 1'b1;
				src_idx = IDX_W'(e);
			end
			if (!r_valid[e])
			begin
				free_found = 1'b1;
				free_idx = IDX_W'(e);
			end
		end

		wr_idx = src_hit ? src_idx : (free_found ? free_idx : r_repl);

		// Hit goes to one port, self-route drops, miss floods
		if (dst_hit)
			mask = (r_port[dst_idx] == sel) ? '0
				: switch_pkg::port_mask_t'(1) << r_port[dst_idx];
		else
			mask = ~(switch_pkg::port_mask_t'(1) << sel);
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_valid <= '0;
			r_repl <= '0;
			o_lkup_ack <= '0;
		end
		else
		begin
			o_lkup_ack <= start ? grant : '0;
			if (start)
				r_valid[wr_idx] <= 1'b1;
			if (start && !src_hit && !free_found)
				r_repl <= (r_repl == IDX_W'(TBL_DEPTH - 1)) ? '0 : r_repl + 1'b1;
		end
	end

	// Entry contents and lookup result
	always_ff @(posedge i_clk)
	begin
		if (start)
		begin
			r_mac[wr_idx] <= src_mac;
			r_port[wr_idx] <= sel;
			o_lkup_mask <= mask;
		end
	end

endmodule

//--- src/ingress_port.sv
//////////////////////////////////////////////////
// Ingress port
// Receive buffer with credit return, header
// lookup and packet forward or drop
//////////////////////////////////////////////////
`timescale 1ns/1ps

module ingress_port #(
	parameter int RX_DEPTH = 4
) (
	input logic i_clk,
	input logic i_reset,
	input logic i_rx_valid,
	input switch_pkg::beat_t i_rx_beat,
	input logic i_rx_last,
	output logic o_rx_credit,
	output logic o_lkup_req,
	output switch_pkg::mac_t o_lkup_src,
	output switch_pkg::mac_t o_lkup_dst,
	input logic i_lkup_ack,
	input switch_pkg::port_mask_t i_lkup_mask,
	output logic o_fwd_req,
	output logic o_fwd_valid,
	input logic i_fwd_grant,
	output switch_pkg::beat_t o_fwd_beat,
	output logic o_fwd_last,
	output switch_pkg::port_mask_t o_fwd_mask,
	input switch_pkg::port_mask_t i_egress_ready
);

	localparam int PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
	localparam int CNT_W = $clog2(RX_DEPTH + 1);

	switch_pkg::beat_t buf_beat [RX_DEPTH];
	logic [RX_DEPTH-1:0] buf_last;
	logic [PTR_W-1:0] r_wr_ptr, r_rd_ptr;
	logic [CNT_W-1:0] r_count;
	switch_pkg::ingress_state_t r_state;
	switch_pkg::port_mask_t r_mask;

	switch_pkg::beat_t head_beat;
	logic head_last;
	logic not_empty;
	logic pop;

	assign head_beat = buf_beat[r_rd_ptr];
	assign head_last = buf_last[r_rd_ptr];
	assign not_empty = (r_count != '0);

	// Header beat carries destination high, source low
	assign o_lkup_dst = head_beat[switch_pkg::BEAT_W-1 -: switch_pkg::MAC_W];
	assign o_lkup_src = head_beat[switch_pkg::MAC_W-1:0];
	assign o_lkup_req = (r_state == switch_pkg::ING_LOOKUP);

	assign o_fwd_req = (r_state == switch_pkg::ING_FORWARD);
	assign o_fwd_beat = head_beat;
	assign o_fwd_last = head_last;
	assign o_fwd_mask = r_mask;

	// Move only when every target can take the beat
	assign o_fwd_valid = o_fwd_req && i_fwd_grant && not_empty
		&& ((r_mask & ~i_egress_ready) == '0);

	assign pop = o_fwd_valid || (r_state == switch_pkg::ING_DROP && not_empty);

	// Sender never overruns, it holds one credit per free slot
	always_ff @(posedge i_clk)
	begin
		if (i_rx_valid)
		begin
			buf_beat[r_wr_ptr] <= i_rx_beat;
			buf_last[r_wr_ptr] <= i_rx_last;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_count <= '0;
			o_rx_credit <= 1'b0;
		end
		else
		begin
			if (i_rx_valid)
				r_wr_ptr <= (r_wr_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
			if (pop)
				r_rd_ptr <= (r_rd_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
			r_count <= r_count + CNT_W'(i_rx_valid) - CNT_W'(pop);
			o_rx_credit <= pop;
		end
	end

	//////////////////////////////////////////////////
	// Packet FSM
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			r_state <= switch_pkg::ING_IDLE;
		else
		begin
			case (r_state)
			switch_pkg::ING_IDLE:
				if (not_empty)
					r_state <= switch_pkg::ING_LOOKUP;
			switch_pkg::ING_LOOKUP:
				if (i_lkup_ack)
					r_state <= (i_lkup_mask == '0) ? switch_pkg::ING_DROP
						: switch_pkg::ING_FORWARD;
			default:
				if (pop && head_last)
					r_state <= switch_pkg::ING_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (r_state == switch_pkg::ING_LOOKUP && i_lkup_ack)
			r_mask <= i_lkup_mask;
	end

endmodule

//--- src/forward_bus.sv
//////////////////////////////////////////////////
// Shared forwarding bus
// One ingress owns it for a whole packet
//////////////////////////////////////////////////
`timescale 1ns/1ps

module forward_bus (
	input logic i_clk,
	input logic i_reset,
	input switch_pkg::port_mask_t i_fwd_req,
	input switch_pkg::port_mask_t i_fwd_valid,
	input switch_pkg::beat_t [switch_pkg::NPORT-1:0] i_fwd_beat,
	input switch_pkg::port_mask_t i_fwd_last,
	input switch_pkg::port_mask_t [switch_pkg::NPORT-1:0] i_fwd_mask,
	output switch_pkg::port_mask_t o_fwd_grant,
	output logic o_bus_valid,
	output switch_pkg::beat_t o_bus_beat,
	output logic o_bus_last,
	output switch_pkg::port_mask_t o_bus_mask
);

	rr_arbiter u_arb (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_req(i_fwd_req),
		.o_grant(o_fwd_grant)
	);

	// Owner select
	always_comb
	begin
		o_bus_valid = 1'b0;
		o_bus_beat = '0;
		o_bus_last = 1'b0;
		o_bus_mask = '0;
		for (int p = 0; p < switch_pkg::NPORT; p++)
		begin
			if (o_fwd_grant[p])
			begin
				o_bus_valid = i_fwd_valid[p];
				o_bus_beat = i_fwd_beat[p];
				o_bus_last = i_fwd_last[p];
				o_bus_mask = i_fwd_mask[p];
			end
		end
	end

endmodule

//--- src/egress_port.sv
//////////////////////////////////////////////////
// Egress port
// Output register and downstream credit counter
//////////////////////////////////////////////////
`timescale 1ns/1ps

module egress_port #(
	parameter int PORT_ID = 0,
	parameter int TX_CREDITS = 3
) (
	input logic i_clk,
	input logic i_reset,
	input logic i_bus_valid,
	input switch_pkg::beat_t i_bus_beat,
	input logic i_bus_last,
	input switch_pkg::port_mask_t i_bus_mask,
	output logic o_ready,
	output logic o_tx_valid,
	output switch_pkg::beat_t o_tx_beat,
	output logic o_tx_last,
	input logic i_tx_credit
);

	localparam int CNT_W = $clog2(TX_CREDITS + 1);

	logic [CNT_W-1:0] r_credits;
	logic accept;

	assign accept = i_bus_valid && i_bus_mask[PORT_ID];

	// A beat in the output register still holds its credit
	assign o_ready = (r_credits > CNT_W'(1)) || (r_credits == CNT_W'(1) && !o_tx_valid);

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_credits <= CNT_W'(TX_CREDITS);
			o_tx_valid <= 1'b0;
			o_tx_last <= 1'b0;
		end
		else
		begin
			r_credits <= r_credits - CNT_W'(o_tx_valid) + CNT_W'(i_tx_credit);
			o_tx_valid <= accept;
			o_tx_last <= accept && i_bus_last;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (accept)
			o_tx_beat <= i_bus_beat;
	end

endmodule

//--- src/switch_core.sv
//////////////////////////////////////////////////
// Learning switch core, four ports
// Ingress ports share the table and one bus
//////////////////////////////////////////////////
`timescale 1ns/1ps

module switch_core #(
	parameter int TBL_DEPTH = 4,
	parameter int RX_DEPTH = 4,
	parameter int TX_CREDITS = 3
) (
	input logic i_clk,
	input logic i_reset,
	input switch_pkg::port_mask_t i_rx_valid,
	input switch_pkg::beat_t [switch_pkg::NPORT-1:0] i_rx_beat,
	input switch_pkg::port_mask_t i_rx_last,
	output switch_pkg::port_mask_t o_rx_credit,
	output switch_pkg::port_mask_t o_tx_valid,
	output switch_pkg::beat_t [switch_pkg::NPORT-1:0] o_tx_beat,
	output switch_pkg::port_mask_t o_tx_last,
	input switch_pkg::port_mask_t i_tx_credit
);

	// Table access
	switch_pkg::port_mask_t lkup_req;
	switch_pkg::port_mask_t lkup_ack;
	switch_pkg::port_mask_t lkup_mask;
	switch_pkg::mac_t [switch_pkg::NPORT-1:0] lkup_src;
	switch_pkg::mac_t [switch_pkg::NPORT-1:0] lkup_dst;

	// Forwarding bus
	switch_pkg::port_mask_t fwd_req;
	switch_pkg::port_mask_t fwd_valid;
	switch_pkg::port_mask_t fwd_grant;
	switch_pkg::beat_t [switch_pkg::NPORT-1:0] fwd_beat;
	switch_pkg::port_mask_t fwd_last;
	switch_pkg::port_mask_t [switch_pkg::NPORT-1:0] fwd_mask;
	logic bus_valid;
	switch_pkg::beat_t bus_beat;
	logic bus_last;
	switch_pkg::port_mask_t bus_mask;
	switch_pkg::port_mask_t egress_ready;

	for (genvar g = 0; g < switch_pkg::NPORT; g++)
	begin : gen_port
		ingress_port #(
			.RX_DEPTH(RX_DEPTH)
		) u_ingress (
			.i_clk(i_clk),
			.i_reset(i_reset),
			.i_rx_valid(i_rx_valid[g]),
			.i_rx_beat(i_rx_beat[g]),
			.i_rx_last(i_rx_last[g]),
			.o_rx_credit(o_rx_credit[g]),
			.o_lkup_req(lkup_req[g]),
			.o_lkup_src(lkup_src[g]),
			.o_lkup_dst(lkup_dst[g]),
			.i_lkup_ack(lkup_ack[g]),
			.i_lkup_mask(lkup_mask),
			.o_fwd_req(fwd_req[g]),
			.o_fwd_valid(fwd_valid[g]),
			.i_fwd_grant(fwd_grant[g]),
			.o_fwd_beat(fwd_beat[g]),
			.o_fwd_last(fwd_last[g]),
			.o_fwd_mask(fwd_mask[g]),
			.i_egress_ready(egress_ready)
		);

		egress_port #(
			.PORT_ID(g),
			.TX_CREDITS(TX_CREDITS)
		) u_egress (
			.i_clk(i_clk),
			.i_reset(i_reset),
			.i_bus_valid(bus_valid),
			.i_bus_beat(bus_beat),
			.i_bus_last(bus_last),
			.i_bus_mask(bus_mask),
			.o_ready(egress_ready[g]),
			.o_tx_valid(o_tx_valid[g]),
			.o_tx_beat(o_tx_beat[g]),
			.o_tx_last(o_tx_last[g]),
			.i_tx_credit(i_tx_credit[g])
		);
	end

	route_table #(
		.TBL_DEPTH(TBL_DEPTH)
	) u_table (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_lkup_req(lkup_req),
		.i_lkup_src(lkup_src),
		.i_lkup_dst(lkup_dst),
		.o_lkup_ack(lkup_ack),
		.o_lkup_mask(lkup_mask)
	);

	forward_bus u_bus (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_fwd_req(fwd_req),
		.i_fwd_valid(fwd_valid),
		.i_fwd_beat(fwd_beat),
		.i_fwd_last(fwd_last),
		.i_fwd_mask(fwd_mask),
		.o_fwd_grant(fwd_grant),
		.o_bus_valid(bus_valid),
		.o_bus_beat(bus_beat),
		.o_bus_last(bus_last),
		.o_bus_mask(bus_mask)
	);

endmodule

//--- tests/egress_port_sva.sv
//////////////////////////////////////////////////
// Egress port credit checks
// Bound to every egress_port instance
//////////////////////////////////////////////////
`timescale 1ns/1ps

module egress_port_sva #(
	parameter int TX_CREDITS = 3,
	parameter int CNT_W = $clog2(TX_CREDITS + 1)
) (
	input logic i_clk,
	input logic i_reset,
	input logic i_tx_valid,
	input logic [CNT_W-1:0] i_credits
);

	// A beat on the output always holds one downstream credit
	a_no_tx_without_credit: assert property (@(posedge i_clk) disable iff (i_reset)
		i_tx_valid |-> i_credits != '0)
		else $error("Egress output valid with a zero credit count");

	a_credit_limit: assert property (@(posedge i_clk) disable iff (i_reset)
		i_credits <= CNT_W'(TX_CREDITS))
		else $error("Egress credit count above its starting value");

	a_quiet_after_reset: assert property (@(posedge i_clk)
		i_reset |=> !i_tx_valid)
		else $error("Egress output valid right after reset");

endmodule

bind egress_port egress_port_sva #(
	.TX_CREDITS(TX_CREDITS)
) u_sva (
	.i_clk(i_clk),
	.i_reset(i_reset),
	.i_tx_valid(o_tx_valid),
	.i_credits(r_credits)
);

//--- tests/switch_core_tb.sv
//////////////////////////////////////////////////
// Switch core testbench
// Random packets, credit model, table model
//////////////////////////////////////////////////
`timescale 1ns/1ps

module switch_core_tb;

	localparam int NPORT = switch_pkg::NPORT;
	localparam int TBL_DEPTH = 4;
	localparam int RX_DEPTH = 4;
	localparam int TX_CREDITS = 3;
	localparam int TIMEOUT = 3000;

	logic i_clk;
	logic i_reset;
	switch_pkg::port_mask_t rx_valid;
	switch_pkg::port_mask_t rx_last;
	switch_pkg::port_mask_t rx_credit;
	switch_pkg::port_mask_t tx_valid;
	switch_pkg::port_mask_t tx_last;
	switch_pkg::port_mask_t tx_credit;
	switch_pkg::beat_t [NPORT-1:0] rx_beat;
	switch_pkg::beat_t [NPORT-1:0] tx_beat;

	integer seed = 89;
	int cycle;
	int credit_gap;
	string test_name;

	// Reference routing table
	logic m_valid [TBL_DEPTH];
	switch_pkg::mac_t m_mac [TBL_DEPTH];
	switch_pkg::port_id_t m_port [TBL_DEPTH];
	int m_repl;

	// Sender queues, expected packets and received beats
	switch_pkg::beat_t send_beat [NPORT][$];
	logic send_last [NPORT][$];
	int rx_cred [NPORT];
	switch_pkg::beat_t pool_beat [64][5];
	int pool_len [64];
	int pool_n;
	int exp_q [NPORT][$];
	switch_pkg::beat_t got [NPORT][$];
	int tx_pend [NPORT][$];
	int tx_out [NPORT];

	switch_core #(
		.TBL_DEPTH(TBL_DEPTH),
		.RX_DEPTH(RX_DEPTH),
		.TX_CREDITS(TX_CREDITS)
	) u_dut (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_rx_valid(rx_valid),
		.i_rx_beat(rx_beat),
		.i_rx_last(rx_last),
		.o_rx_credit(rx_credit),
		.o_tx_valid(tx_valid),
		.o_tx_beat(tx_beat),
		.o_tx_last(tx_last),
		.i_tx_credit(tx_credit)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	task automatic stop_with_error(string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	function automatic switch_pkg::mac_t new_mac();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[47:0];
	endfunction

	// Lookup sees the table before the source is learned
	function automatic switch_pkg::port_mask_t model_lookup_learn(int port,
		switch_pkg::mac_t src, switch_pkg::mac_t dst);
		switch_pkg::port_mask_t mask;
		int hit;
		int slot;
		hit = -1;
		slot = -1;
		mask = '1;
		mask[port] = 1'b0;
		for (int e = 0; e < TBL_DEPTH; e++)
			if (m_valid[e] && m_mac[e] == dst)
				hit = e;
		if (hit >= 0)
		begin
			mask = '0;
			if (int'(m_port[hit]) != port)
				mask[m_port[hit]] = 1'b1;
		end
		for (int e = 0; e < TBL_DEPTH; e++)
			if (m_valid[e] && m_mac[e] == src)
				slot = e;
		for (int e = 0; e < TBL_DEPTH; e++)
			if (slot < 0 && !m_valid[e])
				slot = e;
		// Full table, evict at the replacement pointer
		if (slot < 0)
		begin
			slot = m_repl;
			m_repl = (m_repl + 1) % TBL_DEPTH;
		end
		m_valid[slot] = 1'b1;
		m_mac[slot] = src;
		m_port[slot] = switch_pkg::port_id_t'(port);
		return mask;
	endfunction

	task automatic queue_packet(int port, switch_pkg::mac_t dst, switch_pkg::mac_t src);
		switch_pkg::port_mask_t mask;
		switch_pkg::beat_t beat;
		int len;
		len = 1 + ($unsigned($random(seed)) % 5);
		mask = model_lookup_learn(port, src, dst);
		pool_len[pool_n] = len;
		for (int b = 0; b < len; b++)
		begin
			if (b == 0)
				beat = {dst, src};
			else
				beat = {$random(seed), $random(seed), $random(seed)};
			pool_beat[pool_n][b] = beat;
			send_beat[port].push_back(beat);
			send_last[port].push_back(b == len - 1);
		end
		for (int e = 0; e < NPORT; e++)
			if (mask[e])
				exp_q[e].push_back(pool_n);
		pool_n++;
	endtask

	// Packets from one source keep their order, sources may interleave
	task automatic check_received_packet(int e);
		int pos;
		int idx;
		pos = -1;
		for (int i = 0; i < exp_q[e].size(); i++)
			if (pos < 0 && pool_beat[exp_q[e][i]][0] == got[e][0])
				pos = i;
		assert (pos >= 0)
		else stop_with_error($sformatf("%s: unexpected packet on port %0d with header %h",
			test_name, e, got[e][0]));
		idx = exp_q[e][pos];
		assert (got[e].size() == pool_len[idx])
		else stop_with_error($sformatf("mismatch %s: port %0d length expected %0d actual %0d",
			test_name, e, pool_len[idx], got[e].size()));
		for (int b = 0; b < pool_len[idx]; b++)
			assert (got[e][b] == pool_beat[idx][b])
			else stop_with_error($sformatf("mismatch %s: port %0d beat %0d expected %h actual %h",
				test_name, e, b, pool_beat[idx][b], got[e][b]));
		exp_q[e].delete(pos);
		got[e].delete();
	endtask

	// One clock: sample outputs at the falling edge, return credits
	task automatic advance_cycle();
		int due;
		@(negedge i_clk);
		cycle++;
		for (int e = 0; e < NPORT; e++)
		begin
			if (rx_credit[e])
				rx_cred[e]++;
			assert (rx_cred[e] <= RX_DEPTH)
			else stop_with_error($sformatf("%s: port %0d returned more receive credits than sent",
				test_name, e));
			if (tx_valid[e])
			begin
				tx_out[e]++;
				assert (tx_out[e] <= TX_CREDITS)
				else stop_with_error($sformatf("%s: port %0d sent a beat without a credit",
					test_name, e));
				due = cycle + int'($unsigned($random(seed)) % 4) + credit_gap;
				if (tx_pend[e].size() > 0 && due <= tx_pend[e][$])
					due = tx_pend[e][$] + 1;
				tx_pend[e].push_back(due);
				got[e].push_back(tx_beat[e]);
				if (tx_last[e])
					check_received_packet(e);
			end
			tx_credit[e] = 1'b0;
			if (tx_pend[e].size() > 0 && tx_pend[e][0] <= cycle)
			begin
				tx_credit[e] = 1'b1;
				tx_out[e]--;
				void'(tx_pend[e].pop_front());
			end
		end
	endtask

	task automatic drive_senders();
		for (int p = 0; p < NPORT; p++)
		begin
			rx_valid[p] = 1'b0;
			rx_last[p] = 1'b0;
			if (send_beat[p].size() > 0 && rx_cred[p] > 0)
			begin
				rx_valid[p] = 1'b1;
				rx_beat[p] = send_beat[p].pop_front();
				rx_last[p] = send_last[p].pop_front();
				rx_cred[p]--;
			end
		end
	endtask

	// Optionally also waits for every receive credit to come back
	function automatic logic traffic_drained(logic with_credits);
		logic done;
		done = 1'b1;
		for (int p = 0; p < NPORT; p++)
			if (send_beat[p].size() != 0 || exp_q[p].size() != 0 || got[p].size() != 0
				|| (with_credits && rx_cred[p] != RX_DEPTH))
				done = 1'b0;
		return done;
	endfunction

	function automatic string ingress_states();
		switch_pkg::ingress_state_t s [NPORT];
		string txt;
		s[0] = u_dut.gen_port[0].u_ingress.r_state;
		s[1] = u_dut.gen_port[1].u_ingress.r_state;
		s[2] = u_dut.gen_port[2].u_ingress.r_state;
		s[3] = u_dut.gen_port[3].u_ingress.r_state;
		txt = "";
		for (int p = 0; p < NPORT; p++)
			txt = {txt, " ", s[p].name()};
		return txt;
	endfunction

	task automatic run_until_drained(logic with_credits);
		int waited;
		waited = 0;
		while (!traffic_drained(with_credits))
		begin
			assert (waited < TIMEOUT)
			else stop_with_error($sformatf("%s: traffic did not drain, ingress states%s",
				test_name, ingress_states()));
			advance_cycle();
			drive_senders();
			waited++;
		end
	endtask

	initial
	begin
		switch_pkg::mac_t mac_a;
		switch_pkg::mac_t mac_b;
		switch_pkg::mac_t s_mac [NPORT];
		int dst_port;
		int waited;
		int outstanding;
		i_reset = 1'b1;
		rx_valid = '0;
		rx_last = '0;
		rx_beat = '0;
		tx_credit = '0;
		cycle = 0;
		credit_gap = 0;
		pool_n = 0;
		m_repl = 0;
		for (int e = 0; e < TBL_DEPTH; e++)
			m_valid[e] = 1'b0;
		for (int p = 0; p < NPORT; p++)
		begin
			rx_cred[p] = RX_DEPTH;
			tx_out[p] = 0;
		end
		repeat (3) @(negedge i_clk);
		i_reset = 1'b0;

		test_name = "flood";
		mac_a = new_mac();
		queue_packet(0, new_mac(), mac_a);
		run_until_drained(1'b1);

		test_name = "learn";
		mac_b = new_mac();
		queue_packet(2, mac_a, mac_b);
		run_until_drained(1'b1);

		test_name = "self_drop";
		queue_packet(0, mac_a, new_mac());
		run_until_drained(1'b1);

		// Five new sources walk the pointer over every entry
		test_name = "replace";
		for (int i = 0; i <= TBL_DEPTH; i++)
		begin
			queue_packet(int'($unsigned($random(seed)) % NPORT), mac_b, new_mac());
			run_until_drained(1'b1);
		end
		queue_packet(3, mac_a, new_mac());
		run_until_drained(1'b1);

		test_name = "concurrent";
		for (int p = 0; p < NPORT; p++)
		begin
			s_mac[p] = new_mac();
			queue_packet(p, new_mac(), s_mac[p]);
			run_until_drained(1'b1);
		end
		credit_gap = 6;
		for (int k = 0; k < 4; k++)
			for (int p = 0; p < NPORT; p++)
			begin
				dst_port = (p + 1 + int'($unsigned($random(seed)) % 3)) % NPORT;
				queue_packet(p, s_mac[dst_port], s_mac[p]);
			end
		run_until_drained(1'b0);
		credit_gap = 0;

		test_name = "credits";
		waited = 0;
		outstanding = 1;
		while (outstanding != 0)
		begin
			assert (waited < TIMEOUT)
			else stop_with_error("credits: transmit credits were never returned");
			advance_cycle();
			drive_senders();
			waited++;
			outstanding = 0;
			for (int p = 0; p < NPORT; p++)
				outstanding = outstanding + tx_out[p];
		end
		for (int p = 0; p < NPORT; p++)
			assert (rx_cred[p] == RX_DEPTH)
			else stop_with_error($sformatf("mismatch %s: port %0d expected %0d actual %0d",
				test_name, p, RX_DEPTH, rx_cred[p]));

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- sources.f
src/switch_pkg.sv
src/rr_arbiter.sv
src/route_table.sv
src/ingress_port.sv
src/forward_bus.sv
src/egress_port.sv
src/switch_core.sv
tests/egress_port_sva.sv
tests/switch_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the switch core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module switch_core_tb -Mdir obj_dir -f sources.f

./obj_dir/Vswitch_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
	echo "Result: passed"
	exit 0
else
	echo "Result: failed"
	exit 1
fi
